/* dv/cpuCoreTb.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpuCoreTb;
    import cpuPkg::*;

    localparam int cycleLimit = 4000;

    logic                  clk = 1'b0;
    logic                  rstN = 1'b0;
    logic                  readM;
    logic                  writeM;
    logic [`WORD_SIZE-1:0] address;
    logic [`WORD_SIZE-1:0] writeData;
    logic [`WORD_SIZE-1:0] readData;
    logic                  inputReady;
    logic                  ackOutput;
    logic [`WORD_SIZE-1:0] outputPort;
    logic                  outputValid;
    logic                  halted;
    logic [`WORD_SIZE-1:0] expectedWrite = 16'h3C5A;
    int                    writeErrors;

    logic [15:0] expectQ [$];
    logic        markQ [$];
    string       sectionNames [6] = '{"register ALU", "immediates", "branches",
                                      "load and store", "jump and link", "halt and reset"};
    int          progAddr = 0;
    int          jumpBase;
    int          section = 0;
    int          sectionErrors = 0;
    int          resetErrors = 0;
    int          errorCount = 0;
    int          writeErrorsSeen = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    int          cycleCount = 0;
    int          resetCycles = 0;
    logic        haltSeen = 1'b0;
    logic [15:0] expValue;
    logic        expMark;
    seqStateT    stateNow;

    always #4 clk = ~clk;

    cpuCore cpuCore_inst (
        .clk(clk), .rstN(rstN), .readM(readM), .writeM(writeM),
        .address(address), .writeData(writeData), .readData(readData),
        .inputReady(inputReady), .ackOutput(ackOutput),
        .outputPort(outputPort), .outputValid(outputValid), .halted(halted)
    );

    memoryModel memInst (
        .clk(clk), .rstN(rstN), .readM(readM), .writeM(writeM),
        .address(address), .writeData(writeData), .expectedWrite(expectedWrite),
        .readData(readData), .inputReady(inputReady), .ackOutput(ackOutput),
        .writeErrors(writeErrors)
    );

    function automatic logic [15:0] encR(input logic [1:0] rs, input logic [1:0] rt,
                                         input logic [1:0] rd, input logic [5:0] func);
        return {4'd15, rs, rt, rd, func};
    endfunction

    function automatic logic [15:0] encI(input logic [3:0] op, input logic [1:0] rs,
                                         input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] encJ(input logic [3:0] op, input logic [11:0] target);
        return {op, target};
    endfunction

    task automatic emit(input logic [15:0] word);
        memInst.mem[progAddr] = word;
        progAddr++;
    endtask

    task automatic expectOutput(input logic [15:0] value, input logic isMarker);
        expectQ.push_back(value);
        markQ.push_back(isMarker);
    endtask

    task automatic loadConst(input logic [1:0] r, input logic [15:0] value);
        emit(encI(OP_LHI, 2'd0, r, value[15:8]));
        emit(encI(OP_ORI, r, r, value[7:0]));
    endtask

    task automatic outReg(input logic [1:0] r);
        emit(encR(r, 2'd0, 2'd0, `FUNC_WWD));
    endtask

    task automatic aluCase(input logic [5:0] func, input logic [15:0] value);
        emit(encR(2'd0, 2'd1, 2'd3, func)); // r3 = r0 op r1.
        outReg(2'd3);
        expectOutput(value, 1'b0);
    endtask

    // Each section closes with a marker that lands in r3.
    task automatic endSection(input logic [15:0] marker);
        loadConst(2'd3, marker);
        outReg(2'd3);
        expectOutput(marker, 1'b1);
    endtask

    task automatic finishSection(input int extraErrors);
        if (sectionErrors + extraErrors == 0) begin
            $display("Test %s: pass", sectionNames[section]);
            testsPassed++;
        end else begin
            $display("Test %s: FAILED", sectionNames[section]);
            testsFailed++;
        end
        sectionErrors = 0;
        section++;
    endtask

    task automatic buildProgram();
        for (int i = 0; i < 256; i++) begin
            memInst.mem[i] = {~8'(i), 8'(i)};
        end
        loadConst(2'd0, 16'h1234);
        loadConst(2'd1, 16'h0F0F);
        aluCase(6'd0, 16'h2143);
        aluCase(6'd1, 16'h0325);
        aluCase(6'd2, 16'h0204);
        aluCase(6'd3, 16'h1F3F);
        aluCase(6'd4, 16'hEDCB);
        aluCase(6'd5, 16'hEDCC);
        aluCase(6'd6, 16'h2468);
        aluCase(6'd7, 16'h091A);
        loadConst(2'd1, 16'h8001);
        emit(encR(2'd1, 2'd0, 2'd3, 6'd7)); // Sign bit must be kept.
        outReg(2'd3);
        expectOutput(16'hC000, 1'b0);
        endSection(16'hA001);

        emit(encI(OP_ADI, 2'd0, 2'd1, 8'hFE));
        outReg(2'd1);
        expectOutput(16'h1232, 1'b0);
        emit(encI(OP_ORI, 2'd0, 2'd1, 8'hF0));
        outReg(2'd1);
        expectOutput(16'h12F4, 1'b0);
        emit(encI(OP_LHI, 2'd0, 2'd1, 8'h5A));
        outReg(2'd1);
        expectOutput(16'h5A00, 1'b0);
        endSection(16'hA002);

        // Taken branches skip a WWD of r3; untaken ones output an operand.
        loadConst(2'd0, 16'h0005);
        loadConst(2'd1, 16'h0007);
        loadConst(2'd2, 16'hFFF9);
        loadConst(2'd3, 16'hBAD3);
        emit(encI(OP_BNE, 2'd0, 2'd1, 8'd1));
        outReg(2'd3);
        emit(encI(OP_BNE, 2'd0, 2'd0, 8'd1));
        outReg(2'd0);
        expectOutput(16'h0005, 1'b0);
        emit(encI(OP_BEQ, 2'd0, 2'd0, 8'd1));
        outReg(2'd3);
        emit(encI(OP_BEQ, 2'd0, 2'd1, 8'd1));
        outReg(2'd1);
        expectOutput(16'h0007, 1'b0);
        emit(encI(OP_BGZ, 2'd0, 2'd0, 8'd1));
        outReg(2'd3);
        emit(encI(OP_BGZ, 2'd2, 2'd0, 8'd1));
        outReg(2'd2);
        expectOutput(16'hFFF9, 1'b0);
        emit(encI(OP_BLZ, 2'd2, 2'd0, 8'd1));
        outReg(2'd3);
        emit(encI(OP_BLZ, 2'd0, 2'd0, 8'd1));
        outReg(2'd0);
        expectOutput(16'h0005, 1'b0);
        endSection(16'hA003);

        loadConst(2'd0, 16'h00C0);
        loadConst(2'd1, 16'h3C5A);
        emit(encI(OP_SWD, 2'd0, 2'd1, 8'h05));
        emit(encI(OP_LWD, 2'd0, 2'd3, 8'h05));
        outReg(2'd3);
        expectOutput(16'h3C5A, 1'b0);
        emit(encI(OP_LWD, 2'd0, 2'd3, 8'hFF)); // Offset -1 reads fill word 0xBF.
        outReg(2'd3);
        expectOutput(16'h40BF, 1'b0);
        endSection(16'hA004);

        jumpBase = progAddr;
        emit(encJ(OP_JMP, 12'(jumpBase + 2)));
        outReg(2'd3);
        jumpBase = progAddr;
        emit(encJ(OP_JAL, 12'(jumpBase + 2)));
        emit(encJ(OP_JMP, 12'(jumpBase + 4)));
        outReg(2'd2);
        expectOutput(16'(jumpBase + 1), 1'b0);
        emit(encR(2'd2, 2'd0, 2'd0, `FUNC_JPR));
        jumpBase = progAddr;
        loadConst(2'd0, 16'(jumpBase + 4));
        emit(encR(2'd0, 2'd0, 2'd0, `FUNC_JRL));
        emit(encJ(OP_JMP, 12'(jumpBase + 6)));
        outReg(2'd2);
        expectOutput(16'(jumpBase + 3), 1'b0);
        emit(encR(2'd2, 2'd0, 2'd0, `FUNC_JPR));
        endSection(16'hA005);

        emit(encR(2'd0, 2'd0, 2'd0, `FUNC_HLT));
    endtask

    always @(negedge clk) begin
        if (!rstN) begin
            resetCycles++;
            if (resetCycles > 1) begin
                assert (!readM && !writeM && !outputValid) else begin
                    $display("Fail at %0t: memory strobe or output active in reset", $time);
                    errorCount++;
                    resetErrors++;
                end
            end
        end else begin
            if (haltSeen) begin
                assert (halted && !readM && !outputValid) else begin
                    $display("Fail at %0t: core active after halt", $time);
                    errorCount++;
                    sectionErrors++;
                end
            end
            if (halted) begin
                haltSeen = 1'b1;
            end
            if (outputValid && !haltSeen) begin
                if (expectQ.size() == 0) begin
                    $display("The core produced output %h when none was expected", outputPort);
                    errorCount++;
                    sectionErrors++;
                end else begin
                    expValue = expectQ.pop_front();
                    expMark  = markQ.pop_front();
                    assert (outputPort == expValue) else begin
                        $display("Fail at %0t: %s output %h, expected %h", $time,
                                 sectionNames[section], outputPort, expValue);
                        errorCount++;
                        sectionErrors++;
                    end
                    if (expMark) begin
                        finishSection(writeErrors - writeErrorsSeen);
                        writeErrorsSeen = writeErrors;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            stateNow = cpuCore_inst.executeInst.state;
            $display("Timeout after %0d cycles: the core did not halt, sequencer in %s",
                     cycleCount, stateNow.name());
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        buildProgram();
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        while (!haltSeen) begin
            @(negedge clk);
        end
        repeat (20) @(posedge clk);
        if (expectQ.size() != 0) begin
            $display("The core halted with %0d expected outputs still missing", expectQ.size());
            errorCount++;
            sectionErrors++;
        end
        finishSection(resetErrors);
        errorCount = errorCount + writeErrors;
        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* dv/memoryModel.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module memoryModel (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  readM,
    input  logic                  writeM,
    input  logic [`WORD_SIZE-1:0] address,
    input  logic [`WORD_SIZE-1:0] writeData,
    input  logic [`WORD_SIZE-1:0] expectedWrite,
    output logic [`WORD_SIZE-1:0] readData = '0,
    output logic                  inputReady = 1'b0,
    output logic                  ackOutput = 1'b0,
    output int                    writeErrors = 0
);

    logic [`WORD_SIZE-1:0] mem [256]; // Loaded by the testbench top.
    logic [31:0]           delayDraw;
    int                    seed = 30;
    int                    waitCount = 0;
    logic                  busy = 1'b0;

    // Requests are seen and answered on the falling edge.
    always @(negedge clk) begin
        if (!rstN) begin
            busy       = 1'b0;
            inputReady = 1'b0;
            ackOutput  = 1'b0;
        end else if (inputReady || ackOutput) begin
            inputReady = 1'b0; // The core drops its strobe on this pulse.
            ackOutput  = 1'b0;
        end else if (!busy && (readM || writeM)) begin
            delayDraw = $random(seed);
            waitCount = 1 + int'(delayDraw[1:0]);
            busy      = 1'b1;
        end else if (busy) begin
            waitCount = waitCount - 1;
            if (waitCount == 0) begin
                busy = 1'b0;
                if (readM) begin
                    readData   = mem[address[7:0]];
                    inputReady = 1'b1;
                end else if (writeM) begin
                    mem[address[7:0]] = writeData;
                    ackOutput         = 1'b1;
                    assert (writeData == expectedWrite) else begin
                        $display("Fail at %0t: stored %h, expected %h",
                                 $time, writeData, expectedWrite);
                        writeErrors++;
                    end
                end
            end
        end
    end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module alu (
    input  logic [`WORD_SIZE-1:0] operandA,
    input  logic [`WORD_SIZE-1:0] operandB,
    input  cpuPkg::aluOpT         aluOp,
    output logic [`WORD_SIZE-1:0] result,
    output logic                  zero,
    output logic                  negative
);
    import cpuPkg::*;

    always_comb begin
        case (aluOp)
            ALU_ADD:   result = operandA + operandB;
            ALU_SUB:   result = operandA - operandB;
            ALU_AND:   result = operandA & operandB;
            ALU_ORR:   result = operandA | operandB;
            ALU_NOT:   result = ~operandA;
            ALU_TCP:   result = ~operandA + 1'b1;
            ALU_SHL:   result = operandA << 1;
            ALU_SHR:   result = $signed(operandA) >>> 1; // Sign bit is kept.
            ALU_PASSB: result = operandB;
            ALU_LHI: begin
                // Immediate goes to the upper byte, lower byte cleared.
                result = {operandB[7:0], {(`WORD_SIZE-8){1'b0}}};
            end
            default:   result = '0;
        endcase
    end

    // Flags for the branch decision.
    assign zero     = (result == '0);
    assign negative = result[`WORD_SIZE-1];

endmodule

/* logic/controlDecoder.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module controlDecoder (
    input  logic [`WORD_SIZE-1:0] instruction,
    output cpuPkg::controlT       controls
);
    import cpuPkg::*;

    opcodeT     opcode;
    logic [5:0] func;

    assign opcode = opcodeT'(instruction[15:12]);
    assign func   = instruction[5:0];

    always_comb begin
        controls = '0; // Unknown codes fall through as a no-op.
        case (opcode)
            OP_BNE, OP_BEQ: begin
                controls.branch = 1'b1;
                controls.aluOp  = ALU_SUB;
            end
            OP_BGZ, OP_BLZ: begin
                // Only the sign and zero flags of rs matter here.
                controls.branch = 1'b1;
                controls.aluOp  = ALU_PASSB;
            end
            OP_ADI, OP_ORI, OP_LHI: begin
                controls.regWrite = 1'b1;
                controls.aluSrc   = 1'b1;
                if (opcode == OP_ADI) begin
                    controls.aluOp = ALU_ADD;
                end else if (opcode == OP_ORI) begin
                    controls.aluOp = ALU_ORR;
                end else begin
                    controls.aluOp = ALU_LHI;
                end
            end
            OP_LWD: begin
                controls.regWrite = 1'b1;
                controls.aluSrc   = 1'b1;
                controls.memRead  = 1'b1;
                controls.memToReg = 1'b1;
                controls.aluOp    = ALU_ADD; // Address is rs plus offset.
            end
            OP_SWD: begin
                controls.aluSrc   = 1'b1;
                controls.memWrite = 1'b1;
                controls.aluOp    = ALU_ADD;
            end
            OP_JMP: controls.jump = 1'b1;
            OP_JAL: begin
                controls.jump     = 1'b1;
                controls.link     = 1'b1;
                controls.regWrite = 1'b1;
            end
            OP_RTYPE: begin
                case (func)
                    6'd0: controls.aluOp = ALU_ADD;
                    6'd1: controls.aluOp = ALU_SUB;
                    6'd2: controls.aluOp = ALU_AND;
                    6'd3: controls.aluOp = ALU_ORR;
                    6'd4: controls.aluOp = ALU_NOT;
                    6'd5: controls.aluOp = ALU_TCP;
                    6'd6: controls.aluOp = ALU_SHL;
                    6'd7: controls.aluOp = ALU_SHR;
                    `FUNC_JPR: controls.jumpReg = 1'b1;
                    `FUNC_JRL: begin
                        controls.jumpReg  = 1'b1;
                        controls.link     = 1'b1;
                        controls.regWrite = 1'b1;
                    end
                    `FUNC_WWD: controls.outputWrite = 1'b1;
                    `FUNC_HLT: controls.halt = 1'b1;
                    default: ;
                endcase
                if (func < 6'd8) begin
                    controls.regWrite = 1'b1;
                    controls.regDst   = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

/* logic/cpuCore.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpuCore (
    input  logic                  clk,
    input  logic                  rstN,
    output logic                  readM,
    output logic                  writeM,
    output logic [`WORD_SIZE-1:0] address,
    output logic [`WORD_SIZE-1:0] writeData,
    input  logic [`WORD_SIZE-1:0] readData,
    input  logic                  inputReady,
    input  logic                  ackOutput,
    output logic [`WORD_SIZE-1:0] outputPort,
    output logic                  outputValid,
    output logic                  halted
);
    import cpuPkg::*;

    controlT                    controls;
    logic [`WORD_SIZE-1:0]      instruction;
    logic [`WORD_SIZE-1:0]      regData1;
    logic [`WORD_SIZE-1:0]      regData2;
    logic                       regWriteEnable;
    logic [`REG_ADDR_WIDTH-1:0] regWriteAddr;
    logic [`WORD_SIZE-1:0]      regWriteValue;

    controlDecoder decoderInst (
        .instruction (instruction),
        .controls    (controls)
    );

    // Operands are read from the rs and rt fields.
    registerFile regFileInst (
        .clk         (clk),
        .rstN        (rstN),
        .readAddr1   (instruction[11:10]),
        .readAddr2   (instruction[9:8]),
        .writeEnable (regWriteEnable),
        .writeAddr   (regWriteAddr),
        .writeValue  (regWriteValue),
        .readData1   (regData1),
        .readData2   (regData2)
    );

    executeUnit executeInst (
        .clk            (clk),
        .rstN           (rstN),
        .controls       (controls),
        .regData1       (regData1),
        .regData2       (regData2),
        .readData       (readData),
        .inputReady     (inputReady),
        .ackOutput      (ackOutput),
        .instruction    (instruction),
        .regWriteEnable (regWriteEnable),
        .regWriteAddr   (regWriteAddr),
        .regWriteValue  (regWriteValue),
        .readM          (readM),
        .writeM         (writeM),
        .address        (address),
        .writeData      (writeData),
        .outputPort     (outputPort),
        .outputValid    (outputValid),
        .halted         (halted)
    );

endmodule

/* logic/cpuPkg.sv */
package cpuPkg;

    // Primary opcode in bits 15:12 of every instruction.
    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_BGZ   = 4'd2,
        OP_BLZ   = 4'd3,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_JAL   = 4'd10,
        OP_RTYPE = 4'd15
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ORR,
        ALU_NOT,
        ALU_TCP,
        ALU_SHL,
        ALU_SHR,
        ALU_PASSB,
        ALU_LHI
    } aluOpT;

    typedef struct packed {
        logic  jump;        // Absolute jump to the 12-bit target.
        logic  jumpReg;     // Jump to the address in rs.
        logic  link;        // Write PC plus 1 to register 2.
        logic  branch;
        logic  memToReg;
        logic  memRead;
        logic  memWrite;
        logic  regDst;      // Destination is rd rather than rt.
        logic  regWrite;
        logic  aluSrc;      // Operand B comes from the immediate.
        aluOpT aluOp;
        logic  outputWrite;
        logic  halt;
    } controlT;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALTED
    } seqStateT;

endpackage

/* logic/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data and address width, one memory word.
`define WORD_SIZE 16

// General register file size.
`define NUM_REGS 4
`define REG_ADDR_WIDTH 2

`define RESET_PC 16'd0

// Register-type function codes that are not plain ALU operations.
`define FUNC_JPR 6'd25
`define FUNC_JRL 6'd26
`define FUNC_WWD 6'd28
`define FUNC_HLT 6'd29

`endif

/* logic/executeUnit.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module executeUnit (
    input  logic                       clk,
    input  logic                       rstN,
    input  cpuPkg::controlT            controls,
    input  logic [`WORD_SIZE-1:0]      regData1,
    input  logic [`WORD_SIZE-1:0]      regData2,
    input  logic [`WORD_SIZE-1:0]      readData,
    input  logic                       inputReady,
    input  logic                       ackOutput,
    output logic [`WORD_SIZE-1:0]      instruction,
    output logic                       regWriteEnable,
    output logic [`REG_ADDR_WIDTH-1:0] regWriteAddr,
    output logic [`WORD_SIZE-1:0]      regWriteValue,
    output logic                       readM,
    output logic                       writeM,
    output logic [`WORD_SIZE-1:0]      address,
    output logic [`WORD_SIZE-1:0]      writeData,
    output logic [`WORD_SIZE-1:0]      outputPort,
    output logic                       outputValid,
    output logic                       halted
);
    import cpuPkg::*;

    seqStateT              state;
    opcodeT                opcode;
    logic [`WORD_SIZE-1:0] pc;
    logic [`WORD_SIZE-1:0] regA;
    logic [`WORD_SIZE-1:0] regB;
    logic [`WORD_SIZE-1:0] aluOut;
    logic [`WORD_SIZE-1:0] memData;
    logic [`WORD_SIZE-1:0] immSext;
    logic [`WORD_SIZE-1:0] immZext;
    logic [`WORD_SIZE-1:0] operandB;
    logic [`WORD_SIZE-1:0] aluResult;
    logic [`WORD_SIZE-1:0] pcPlus1;
    logic [`WORD_SIZE-1:0] nextPc;
    logic                  aluZero;
    logic                  aluNegative;
    logic                  signTest;
    logic                  takeBranch;
    logic                  branchTaken;

    assign opcode   = opcodeT'(instruction[15:12]);
    assign immSext  = {{(`WORD_SIZE-8){instruction[7]}}, instruction[7:0]};
    assign immZext  = {{(`WORD_SIZE-8){1'b0}}, instruction[7:0]};
    assign signTest = controls.branch && (opcode == OP_BGZ || opcode == OP_BLZ);

    always_comb begin
        if (controls.aluSrc) begin
            operandB = (opcode == OP_ORI) ? immZext : immSext;
        end else if (signTest) begin
            operandB = regA; // BGZ and BLZ look at rs alone.
        end else begin
            operandB = regB;
        end
    end

    alu aluInst (
        .operandA (regA),
        .operandB (operandB),
        .aluOp    (controls.aluOp),
        .result   (aluResult),
        .zero     (aluZero),
        .negative (aluNegative)
    );

    always_comb begin
        case (opcode)
            OP_BNE:  takeBranch = !aluZero;
            OP_BEQ:  takeBranch = aluZero;
            OP_BGZ:  takeBranch = !aluZero && !aluNegative;
            OP_BLZ:  takeBranch = aluNegative;
            default: takeBranch = 1'b0;
        endcase
    end

    assign pcPlus1 = pc + 1'b1;

    always_comb begin
        if (controls.jumpReg) begin
            nextPc = regA;
        end else if (controls.jump) begin
            nextPc = {pc[`WORD_SIZE-1:12], instruction[11:0]};
        end else if (branchTaken) begin
            nextPc = pcPlus1 + immSext;
        end else begin
            nextPc = pcPlus1;
        end
    end

    // Register writes commit only in WRITEBACK. Links always go to register 2.
    assign regWriteEnable = (state == WRITEBACK) && controls.regWrite;
    assign regWriteAddr   = controls.link ? `REG_ADDR_WIDTH'd2 :
                            (controls.regDst ? instruction[7:6] : instruction[9:8]);
    assign regWriteValue  = controls.link ? pcPlus1 :
                            (controls.memToReg ? memData : aluOut);

    assign outputPort  = regA;
    assign outputValid = (state == WRITEBACK) && controls.outputWrite;
    assign halted      = (state == HALTED) || (state == WRITEBACK && controls.halt);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state       <= FETCH;
            pc          <= `RESET_PC;
            readM       <= 1'b0;
            writeM      <= 1'b0;
            branchTaken <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (readM && inputReady) begin
                        readM <= 1'b0;
                        state <= DECODE;
                    end else begin
                        readM <= 1'b1; // First fetch after reset.
                    end
                end
                DECODE: state <= EXECUTE;
                EXECUTE: begin
                    branchTaken <= controls.branch && takeBranch;
                    if (controls.memRead) begin
                        readM <= 1'b1;
                        state <= MEMORY;
                    end else if (controls.memWrite) begin
                        writeM <= 1'b1;
                        state  <= MEMORY;
                    end else begin
                        state <= WRITEBACK;
                    end
                end
                MEMORY: begin
                    // Hold the strobe until memory answers.
                    if (readM && inputReady) begin
                        readM <= 1'b0;
                        state <= WRITEBACK;
                    end
                    if (writeM && ackOutput) begin
                        writeM <= 1'b0;
                        state  <= WRITEBACK;
                    end
                end
                WRITEBACK: begin
                    if (controls.halt) begin
                        state <= HALTED;
                    end else begin
                        pc    <= nextPc;
                        readM <= 1'b1; // Next fetch starts right away.
                        state <= FETCH;
                    end
                end
                HALTED: state <= HALTED;
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            FETCH: begin
                address <= pc;
                if (readM && inputReady) begin
                    instruction <= readData;
                end
            end
            DECODE: begin
                regA <= regData1;
                regB <= regData2;
            end
            EXECUTE: begin
                aluOut    <= aluResult;
                address   <= aluResult;
                writeData <= regB;
            end
            MEMORY: begin
                if (readM && inputReady) begin
                    memData <= readData;
                end
            end
            WRITEBACK: address <= nextPc;
            default: ;
        endcase
    end

endmodule

/* logic/registerFile.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module registerFile (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddr1,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddr2,
    input  logic                       writeEnable,
    input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
    input  logic [`WORD_SIZE-1:0]      writeValue,
    output logic [`WORD_SIZE-1:0]      readData1,
    output logic [`WORD_SIZE-1:0]      readData2
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

    // Both read ports are combinational.
    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeValue;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log.
verilator --binary --timing --assert -f src.f --top-module cpuCoreTb -o simv \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || { cat sim.log; echo "Simulation failed"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1
grep -q "No errors" sim.log && exit 0 || exit 1

/* src.f */
+incdir+logic
logic/cpuPkg.sv
logic/controlDecoder.sv
logic/registerFile.sv
logic/alu.sv
logic/executeUnit.sv
logic/cpuCore.sv
dv/memoryModel.sv
dv/cpuCoreTb.sv
